/* src/noc_pkg.sv */
// shared definitions for the mesh router
// port direction enum, coordinate, node id and flit typedefs
// flit field positions and fifo sizing
package noc_pkg;

  // ports and directions
  localparam int NumPorts = 5;
  localparam int DirWidth = 3;

  // the same encoding names ports, requests and the look-ahead field
  typedef enum logic [DirWidth-1:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } dir_e;

  // port index, used by the allocator pointers
  typedef logic [DirWidth-1:0] port_idx_t;

  // one bit per port, requests and grants
  typedef logic [NumPorts-1:0] port_mask_t;

  // mesh coordinates
  localparam int CoordWidth = 3;

  typedef logic [CoordWidth-1:0] coord_t;

  // x in the low half, y in the high half
  typedef logic [2*CoordWidth-1:0] node_id_t;

  // flit layout
  localparam int FlitWidth    = 32;
  localparam int DstXLsb      = 0;
  localparam int DstYLsb      = DstXLsb + CoordWidth;
  localparam int LaDirLsb     = DstYLsb + CoordWidth;
  localparam int PayloadLsb   = LaDirLsb + DirWidth;
  localparam int PayloadWidth = FlitWidth - PayloadLsb;

  typedef logic [FlitWidth-1:0] flit_t;

  // input fifo
  localparam int FifoDepth = 4;
  localparam int PtrWidth  = $clog2(FifoDepth);

  typedef logic [PtrWidth-1:0] fifo_ptr_t;

  // one extra bit so a full fifo can be told from an empty one
  typedef logic [PtrWidth:0] fifo_cnt_t;

endpackage

/* src/xy_route_calc.sv */
// look-ahead route step
// moves a node coordinate one hop and picks the xy direction from there
`timescale 1ns/1ps

module xy_route_calc (
  input  noc_pkg::node_id_t here_id_i,
  input  noc_pkg::dir_e     hop_dir_i,
  input  noc_pkg::coord_t   dst_x_i,
  input  noc_pkg::coord_t   dst_y_i,
  output noc_pkg::dir_e     route_dir_o
);

  noc_pkg::coord_t nxt_x;
  noc_pkg::coord_t nxt_y;

  // coordinate of the router the flit reaches after this hop
  always_comb begin
    nxt_x = here_id_i[noc_pkg::CoordWidth-1:0];
    nxt_y = here_id_i[2*noc_pkg::CoordWidth-1:noc_pkg::CoordWidth];
    case (hop_dir_i)
      noc_pkg::North: begin
        nxt_y = nxt_y + 1'b1;
      end
      noc_pkg::South: begin
        nxt_y = nxt_y - 1'b1;
      end
      noc_pkg::East: begin
        nxt_x = nxt_x + 1'b1;
      end
      noc_pkg::West: begin
        nxt_x = nxt_x - 1'b1;
      end
      default: begin
        // a local hop keeps the coordinate of this router
      end
    endcase
  end

  // dimension order routes x first and then y
  always_comb begin
    if (dst_x_i > nxt_x) begin
      route_dir_o = noc_pkg::East;
    end else if (dst_x_i < nxt_x) begin
      route_dir_o = noc_pkg::West;
    end else if (dst_y_i > nxt_y) begin
      route_dir_o = noc_pkg::North;
    end else if (dst_y_i < nxt_y) begin
      route_dir_o = noc_pkg::South;
    end else begin
      route_dir_o = noc_pkg::Local;
    end
  end

endmodule

/* src/input_port.sv */
// router input port
// circular input fifo with overflow strobe, output request from the head
// flit, and look-ahead rewrite of the departing head
`timescale 1ns/1ps

module input_port #(
  parameter bit IsLocal = 1'b0
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  noc_pkg::node_id_t   xy_id_i,
  input  logic                in_valid_i,
  input  noc_pkg::flit_t      in_flit_i,
  input  logic                grant_i,
  output noc_pkg::port_mask_t req_o,
  output noc_pkg::flit_t      head_flit_o,
  output logic                overflow_o
);

  noc_pkg::flit_t     fifo_mem [noc_pkg::FifoDepth];
  noc_pkg::fifo_ptr_t wr_ptr_q;
  noc_pkg::fifo_ptr_t rd_ptr_q;
  noc_pkg::fifo_cnt_t count_q;

  logic           full;
  logic           empty;
  logic           push;
  logic           pop;
  noc_pkg::dir_e  inj_dir;
  noc_pkg::flit_t wr_flit;
  noc_pkg::flit_t head_flit;
  noc_pkg::dir_e  head_dir;
  noc_pkg::dir_e  next_dir;

  assign full  = (count_q == noc_pkg::fifo_cnt_t'(noc_pkg::FifoDepth));
  assign empty = (count_q == '0);
  assign push  = in_valid_i && !full;
  assign pop   = grant_i && !empty;

  // a strobe into a full fifo is lost
  assign overflow_o = in_valid_i && full;

  // route at this router for injected flits
  xy_route_calc i_inj_route (
    .here_id_i   (xy_id_i),
    .hop_dir_i   (noc_pkg::Local),
    .dst_x_i     (in_flit_i[noc_pkg::DstXLsb +: noc_pkg::CoordWidth]),
    .dst_y_i     (in_flit_i[noc_pkg::DstYLsb +: noc_pkg::CoordWidth]),
    .route_dir_o (inj_dir)
  );

  always_comb begin
    wr_flit = in_flit_i;
    if (IsLocal) begin
      wr_flit[noc_pkg::LaDirLsb +: noc_pkg::DirWidth] = inj_dir;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::fifo_ptr_t'(noc_pkg::FifoDepth - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::fifo_ptr_t'(noc_pkg::FifoDepth - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + noc_pkg::fifo_cnt_t'(push) - noc_pkg::fifo_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= wr_flit;
    end
  end

  // head flit and the output it asks for
  assign head_flit = fifo_mem[rd_ptr_q];
  assign head_dir  = noc_pkg::dir_e'(head_flit[noc_pkg::LaDirLsb +: noc_pkg::DirWidth]);
  assign req_o     = empty ? '0 : (noc_pkg::port_mask_t'(1) << head_dir);

  // route the flit will take at the next router
  xy_route_calc i_la_route (
    .here_id_i   (xy_id_i),
    .hop_dir_i   (head_dir),
    .dst_x_i     (head_flit[noc_pkg::DstXLsb +: noc_pkg::CoordWidth]),
    .dst_y_i     (head_flit[noc_pkg::DstYLsb +: noc_pkg::CoordWidth]),
    .route_dir_o (next_dir)
  );

  always_comb begin
    head_flit_o = head_flit;
    // ejecting flits keep local
    if (head_dir != noc_pkg::Local) begin
      head_flit_o[noc_pkg::LaDirLsb +: noc_pkg::DirWidth] = next_dir;
    end
  end

endmodule

/* src/switch_alloc.sv */
// switch allocator
// one round-robin arbiter per output, grant rows indexed by input
`timescale 1ns/1ps

module switch_alloc (
  input  logic                clk_i,
  input  logic                reset_i,
  input  noc_pkg::port_mask_t req_i   [noc_pkg::NumPorts],
  output noc_pkg::port_mask_t grant_o [noc_pkg::NumPorts]
);

  // first requester at or after the pointer, wrapping around
  function automatic noc_pkg::port_idx_t rr_pick(input noc_pkg::port_mask_t req,
                                                 input noc_pkg::port_idx_t  ptr);
    noc_pkg::port_mask_t upper;
    noc_pkg::port_idx_t  pick;
    for (int i = 0; i < noc_pkg::NumPorts; i++) begin
      upper[i] = req[i] && (noc_pkg::port_idx_t'(i) >= ptr);
    end
    if (upper == '0) begin
      upper = req;
    end
    pick = '0;
    for (int i = noc_pkg::NumPorts - 1; i >= 0; i--) begin
      if (upper[i]) begin
        pick = noc_pkg::port_idx_t'(i);
      end
    end
    return pick;
  endfunction

  logic               win_valid [noc_pkg::NumPorts];
  noc_pkg::port_idx_t win_idx   [noc_pkg::NumPorts];

  for (genvar o = 0; o < noc_pkg::NumPorts; o++) begin : gen_out_arb
    noc_pkg::port_mask_t req_col;
    noc_pkg::port_idx_t  ptr_q;

    // requests of all inputs for this output
    for (genvar i = 0; i < noc_pkg::NumPorts; i++) begin : gen_col
      assign req_col[i] = req_i[i][o];
    end

    assign win_valid[o] = |req_col;
    assign win_idx[o]   = rr_pick(req_col, ptr_q);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        ptr_q <= noc_pkg::Local;
      end else if (win_valid[o]) begin
        // winner drops to lowest priority
        ptr_q <= (win_idx[o] == noc_pkg::port_idx_t'(noc_pkg::NumPorts - 1)) ?
                 '0 : win_idx[o] + 1'b1;
      end
    end
  end

  // each input requests a single output, so rows stay one-hot
  always_comb begin
    for (int i = 0; i < noc_pkg::NumPorts; i++) begin
      grant_o[i] = '0;
    end
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      if (win_valid[o]) begin
        grant_o[win_idx[o]][o] = 1'b1;
      end
    end
  end

endmodule

/* src/crossbar.sv */
// registered crossbar
// per output, selects the granted input flit and registers it with a valid
`timescale 1ns/1ps

module crossbar (
  input  logic                clk_i,
  input  logic                reset_i,
  input  noc_pkg::port_mask_t grant_i     [noc_pkg::NumPorts],
  input  noc_pkg::flit_t      head_flit_i [noc_pkg::NumPorts],
  output logic                out_valid_o [noc_pkg::NumPorts],
  output noc_pkg::flit_t      out_flit_o  [noc_pkg::NumPorts]
);

  logic           sel_valid [noc_pkg::NumPorts];
  noc_pkg::flit_t sel_flit  [noc_pkg::NumPorts];

  // and-or mux, at most one input is granted per output
  always_comb begin
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      sel_valid[o] = 1'b0;
      sel_flit[o]  = '0;
      for (int i = 0; i < noc_pkg::NumPorts; i++) begin
        if (grant_i[i][o]) begin
          sel_valid[o] = 1'b1;
          sel_flit[o]  = sel_flit[o] | head_flit_i[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      if (reset_i) begin
        out_valid_o[o] <= 1'b0;
      end else begin
        out_valid_o[o] <= sel_valid[o];
      end
    end
  end

  // link data holds while the output is idle
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      if (sel_valid[o]) begin
        out_flit_o[o] <= sel_flit[o];
      end
    end
  end

endmodule

/* src/mesh_router.sv */
// five-port mesh router with look-ahead xy routing
// five input ports, a switch allocator and a registered crossbar
`timescale 1ns/1ps

module mesh_router (
  input  logic              clk_i,
  input  logic              reset_i,
  input  noc_pkg::node_id_t xy_id_i,
  input  logic              in_valid_i  [noc_pkg::NumPorts],
  input  noc_pkg::flit_t    in_flit_i   [noc_pkg::NumPorts],
  output logic              out_valid_o [noc_pkg::NumPorts],
  output noc_pkg::flit_t    out_flit_o  [noc_pkg::NumPorts],
  output logic              overflow_o  [noc_pkg::NumPorts]
);

  noc_pkg::port_mask_t req       [noc_pkg::NumPorts];
  noc_pkg::port_mask_t grant     [noc_pkg::NumPorts];
  noc_pkg::flit_t      head_flit [noc_pkg::NumPorts];

  // port index follows the direction encoding
  for (genvar p = 0; p < noc_pkg::NumPorts; p++) begin : gen_in_port
    logic port_grant;

    // an input holds at most one grant, so any bit of its row pops the head
    assign port_grant = |grant[p];

    input_port #(
      .IsLocal (p == noc_pkg::Local)
    ) i_input_port (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .xy_id_i     (xy_id_i),
      .in_valid_i  (in_valid_i[p]),
      .in_flit_i   (in_flit_i[p]),
      .grant_i     (port_grant),
      .req_o       (req[p]),
      .head_flit_o (head_flit[p]),
      .overflow_o  (overflow_o[p])
    );
  end

  switch_alloc i_switch_alloc (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req),
    .grant_o (grant)
  );

  crossbar i_crossbar (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .grant_i     (grant),
    .head_flit_i (head_flit),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o)
  );

endmodule

/* test/mesh_router_checker.sv */
// concurrent assertions on the router output links and overflow strobes
`timescale 1ns/1ps

module mesh_router_checker (
  input logic           clk_i,
  input logic           reset_i,
  input logic           in_valid_i  [noc_pkg::NumPorts],
  input logic           out_valid_i [noc_pkg::NumPorts],
  input noc_pkg::flit_t out_flit_i  [noc_pkg::NumPorts],
  input logic           overflow_i  [noc_pkg::NumPorts]
);

  for (genvar p = 0; p < noc_pkg::NumPorts; p++) begin : gen_port
    // links are idle during reset and the cycle after
    a_reset_idle : assert property (@(posedge clk_i) reset_i |=> !out_valid_i[p])
      else $error("output %0d valid during or right after reset", p);

    // look-ahead code stays inside the direction encoding
    a_la_legal : assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_i[p] |-> out_flit_i[p][noc_pkg::LaDirLsb +: 3] <= noc_pkg::West)
      else $error("output %0d carries an illegal look-ahead code", p);

    a_ovf_strobe : assert property (@(posedge clk_i) disable iff (reset_i)
      overflow_i[p] |-> in_valid_i[p])
      else $error("overflow on port %0d without an input strobe", p);
  end

  // ejected flits keep local
  a_eject_local : assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i[noc_pkg::Local] |->
      out_flit_i[noc_pkg::Local][noc_pkg::LaDirLsb +: 3] == noc_pkg::Local)
    else $error("flit on the local output has a non-local look-ahead");

endmodule

bind mesh_router mesh_router_checker i_mesh_router_checker (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .in_valid_i  (in_valid_i),
  .out_valid_i (out_valid_o),
  .out_flit_i  (out_flit_o),
  .overflow_i  (overflow_o)
);

/* test/mesh_router_tb.sv */
// testbench for the five-port mesh router
// stimulus table, xy reference model, scoreboard, timeout and status report
`timescale 1ns/1ps

module mesh_router_tb;

  localparam int NumRows       = 22;
  localparam int NumGroups     = 12;
  localparam int LoneGroups    = 8;
  localparam int MixGroup      = 10;
  localparam int OvfCycles     = 12;
  localparam int TimeoutCycles = NumRows * 8 + 200;
  localparam int HereX         = 3;
  localparam int HereY         = 4;

  logic              clk;
  logic              reset;
  noc_pkg::node_id_t xy_id;
  logic              in_valid  [noc_pkg::NumPorts];
  noc_pkg::flit_t    in_flit   [noc_pkg::NumPorts];
  logic              out_valid [noc_pkg::NumPorts];
  noc_pkg::flit_t    out_flit  [noc_pkg::NumPorts];
  logic              overflow  [noc_pkg::NumPorts];

  // stimulus table columns
  int row_port [NumRows];
  int row_dx   [NumRows];
  int row_dy   [NumRows];
  int row_la   [NumRows];
  int row_pay  [NumRows];
  int row_grp  [NumRows];
  int row_sync [NumRows];
  int row_cnt;

  // scoreboard entry: test 57:55, cycle 54:39, exact 38, src 37:35, out 34:32, flit 31:0
  logic [63:0] exp_q [$];
  int          cyc;
  int          inj_cnt;
  int          deliv_cnt;
  int          drop_cnt;
  int          seed;
  logic        allow_ovf;

  mesh_router mesh_router_inst (
    .clk_i       (clk),
    .reset_i     (reset),
    .xy_id_i     (xy_id),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit),
    .overflow_o  (overflow)
  );

  always #2 clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic string test_name(input int id);
    case (id)
      0: return "lone_network";
      1: return "local_inject_eject";
      2: return "contention";
      3: return "overflow";
      default: return "mixed";
    endcase
  endfunction

  // xy rule, x first then y
  function automatic int xy_dir(input int cx, input int cy, input int dx, input int dy);
    if (dx > cx) return noc_pkg::East;
    if (dx < cx) return noc_pkg::West;
    if (dy > cy) return noc_pkg::North;
    if (dy < cy) return noc_pkg::South;
    return noc_pkg::Local;
  endfunction

  task automatic add_row(input int port, input int dx, input int dy, input int la,
                         input int pay, input int grp, input int sync);
    row_port[row_cnt] = port;
    row_dx[row_cnt]   = dx;
    row_dy[row_cnt]   = dy;
    row_la[row_cnt]   = la;
    row_pay[row_cnt]  = pay;
    row_grp[row_cnt]  = grp;
    row_sync[row_cnt] = sync;
    row_cnt++;
  endtask

  // strobes one flit and records what the model expects from it
  task automatic inject(input int port, input int dx, input int dy, input int la,
                        input int pay, input int test, input int exact);
    noc_pkg::flit_t f;
    noc_pkg::flit_t e;
    int             out_dir;
    int             nx;
    int             ny;
    int             la_out;
    f = '0;
    f[noc_pkg::DstXLsb +: noc_pkg::CoordWidth]     = 3'(dx);
    f[noc_pkg::DstYLsb +: noc_pkg::CoordWidth]     = 3'(dy);
    f[noc_pkg::LaDirLsb +: 3]                      = 3'(la);
    f[noc_pkg::PayloadLsb +: noc_pkg::PayloadWidth] = 23'(pay);
    out_dir = (port == noc_pkg::Local) ? xy_dir(HereX, HereY, dx, dy) : la;
    nx = HereX;
    ny = HereY;
    case (out_dir)
      noc_pkg::North: ny = ny + 1;
      noc_pkg::South: ny = ny - 1;
      noc_pkg::East:  nx = nx + 1;
      noc_pkg::West:  nx = nx - 1;
      default: ;
    endcase
    la_out = (out_dir == noc_pkg::Local) ? noc_pkg::Local : xy_dir(nx, ny, dx, dy);
    e = f;
    e[noc_pkg::LaDirLsb +: 3] = 3'(la_out);
    exp_q.push_back({6'd0, 3'(test), 16'(cyc), 1'(exact), 3'(port), 3'(out_dir), e});
    in_valid[port] = 1'b1;
    in_flit[port]  = f;
    inj_cnt++;
  endtask

  task automatic clear_inputs();
    for (int p = 0; p < noc_pkg::NumPorts; p++) begin
      in_valid[p] = 1'b0;
      in_flit[p]  = '0;
    end
  endtask

  task automatic wait_drain();
    clear_inputs();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // one cycle of strobes for every row of the group
  task automatic apply_group(input int g);
    int sync;
    int test;
    sync = 0;
    test = (g < 5) ? 0 : (g < LoneGroups) ? 1 : (g < MixGroup) ? 2 : 4;
    clear_inputs();
    for (int r = 0; r < row_cnt; r++) begin
      if (row_grp[r] == g) begin
        inject(row_port[r], row_dx[r], row_dy[r], row_la[r], row_pay[r], test,
               g < LoneGroups);
        sync = sync | row_sync[r];
      end
    end
    @(negedge clk);
    if (sync != 0) begin
      wait_drain();
    end
  endtask

  // four network inputs stream toward west, the fifos fill up
  task automatic run_overflow();
    int pay;
    allow_ovf = 1'b1;
    for (int c = 0; c < OvfCycles; c++) begin
      clear_inputs();
      for (int p = 1; p < noc_pkg::NumPorts; p++) begin
        pay = {$random(seed)} & 32'h7fff;
        inject(p, 0, 4, noc_pkg::West, (pay << 8) | (c * 4 + p), 3, 0);
      end
      @(negedge clk);
    end
    wait_drain();
    allow_ovf = 1'b0;
    assert (drop_cnt > 0) else report_fail("no flit was dropped in the overflow phase");
    assert (deliv_cnt + drop_cnt == inj_cnt)
      else report_fail("delivered and dropped flits do not add up to injected flits");
  endtask

  task automatic drop_flit(input int p, input noc_pkg::flit_t f);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i][37:35] == 3'(p) &&
          exp_q[i][31:noc_pkg::PayloadLsb] == f[31:noc_pkg::PayloadLsb]) begin
        idx = i;
      end
    end
    assert (idx >= 0) else report_fail($sformatf("dropped flit %h on port %0d unknown", f, p));
    exp_q.delete(idx);
    drop_cnt++;
  endtask

  task automatic check_output(input int p, input noc_pkg::flit_t f);
    int          idx;
    logic [63:0] ent;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i][34:32] == 3'(p) &&
          exp_q[i][31:noc_pkg::PayloadLsb] == f[31:noc_pkg::PayloadLsb]) begin
        idx = i;
      end
    end
    assert (idx >= 0)
      else report_fail($sformatf("flit %h on output %0d matches no expected flit", f, p));
    ent = exp_q[idx];
    // an older flit from the same input to the same output must leave first
    for (int j = 0; j < idx; j++) begin
      assert (!(exp_q[j][34:32] == ent[34:32] && exp_q[j][37:35] == ent[37:35]))
        else report_fail($sformatf("flit %h on output %0d left out of order", f, p));
    end
    assert (f === ent[31:0])
      else report_fail($sformatf("Mismatch %s: expected %h actual %h",
                                 test_name(ent[57:55]), ent[31:0], f));
    if (ent[38]) begin
      assert (cyc == ent[54:39] + 2)
        else report_fail($sformatf("Mismatch %s: expected cycle %0d actual %0d",
                                   test_name(ent[57:55]), ent[54:39] + 2, cyc));
    end
    exp_q.delete(idx);
    deliv_cnt++;
  endtask

  // scoreboard and timeout, outputs are stable at the rising edge
  always @(posedge clk) begin
    if (!reset) begin
      for (int p = 0; p < noc_pkg::NumPorts; p++) begin
        if (overflow[p]) begin
          assert (allow_ovf && in_valid[p])
            else report_fail($sformatf("unexpected overflow on port %0d", p));
          drop_flit(p, in_flit[p]);
        end
        if (out_valid[p]) begin
          check_output(p, out_flit[p]);
        end
      end
    end
    assert (cyc < TimeoutCycles)
      else report_fail("timeout, flits were never delivered");
    cyc++;
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    xy_id     = {3'(HereY), 3'(HereX)};
    seed      = 32'h75c6952f;
    cyc       = 0;
    inj_cnt   = 0;
    deliv_cnt = 0;
    drop_cnt  = 0;
    allow_ovf = 1'b0;
    row_cnt   = 0;
    clear_inputs();

    // port, dst x, dst y, look-ahead in, payload, group, drain after group
    add_row(1, 3, 0, noc_pkg::South, 'h101, 0, 1);
    add_row(2, 0, 4, noc_pkg::West,  'h102, 1, 1);
    add_row(3, 3, 7, noc_pkg::North, 'h103, 2, 1);
    add_row(4, 6, 4, noc_pkg::East,  'h104, 3, 1);
    add_row(4, 4, 4, noc_pkg::East,  'h105, 4, 1);
    add_row(0, 5, 1, noc_pkg::Local, 'h106, 5, 1);
    add_row(0, 3, 6, noc_pkg::Local, 'h107, 6, 1);
    add_row(4, 3, 4, noc_pkg::Local, 'h108, 7, 1);
    add_row(0, 6, 2, noc_pkg::Local, 'h201, 8, 0);
    add_row(1, 5, 5, noc_pkg::East,  'h202, 8, 0);
    add_row(3, 7, 0, noc_pkg::East,  'h203, 8, 0);
    add_row(4, 4, 1, noc_pkg::East,  'h204, 8, 0);
    add_row(1, 6, 6, noc_pkg::East,  'h205, 9, 0);
    add_row(3, 5, 3, noc_pkg::East,  'h206, 9, 1);
    add_row(0, 0, 0, noc_pkg::Local, 'h301, 10, 0);
    add_row(1, 3, 4, noc_pkg::Local, 'h302, 10, 0);
    add_row(2, 3, 6, noc_pkg::North, 'h303, 10, 0);
    add_row(3, 7, 4, noc_pkg::East,  'h304, 10, 0);
    add_row(4, 2, 1, noc_pkg::South, 'h305, 10, 0);
    add_row(2, 3, 1, noc_pkg::South, 'h306, 11, 0);
    add_row(3, 1, 7, noc_pkg::West,  'h307, 11, 0);
    add_row(0, 3, 4, noc_pkg::Local, 'h308, 11, 1);

    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);

    for (int g = 0; g < NumGroups; g++) begin
      if (g == MixGroup) begin
        run_overflow();
      end
      apply_group(g);
    end
    wait_drain();
    repeat (4) @(negedge clk);

    if (exp_q.size() == 0 && deliv_cnt + drop_cnt == inj_cnt) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_fail("scoreboard not empty at the end of the run");
    end
  end

endmodule

/* list.f */
src/noc_pkg.sv
src/xy_route_calc.sv
src/input_port.sv
src/switch_alloc.sv
src/crossbar.sv
src/mesh_router.sv
test/mesh_router_checker.sv
test/mesh_router_tb.sv
